/* common/agc_loop_pkg.sv */
package agc_loop_pkg;

    ////////////////////
    // Bus and word widths
    localparam int data_w   = 32;
    localparam int addr_w   = 8;
    localparam int scale_w  = 17;
    localparam int offset_w = 16;

    ////////////////////
    // Control loop constants
    localparam logic [scale_w-1:0]  start_scale  = 17'd1800;
    localparam logic [offset_w-1:0] start_offset = 16'd0;
    localparam int scale_step    = 30;     // Scale change per loop pass
    localparam int offset_step   = 25;     // Offset change per loop pass
    localparam int target_rms_sq = 16;
    localparam int rms_sq_tol    = 0;
    localparam int offset_tol    = 5;      // Allowed above/below count mismatch
    localparam int rms_shift     = 13;
    localparam int scale_floor   = 300;
    localparam int scale_ceil    = 130000;
    localparam int boot_cycles   = 31;
    localparam int n_info        = 6;

    // Meaning of the stored information words
    localparam int info_rms_idx    = 1;    // Mean-square sum
    localparam int info_above_idx  = 2;
    localparam int info_below_idx  = 3;
    localparam int info_scale_idx  = 4;
    localparam int info_offset_idx = 5;

    ////////////////////
    // Downstream AGC module map
    localparam logic [addr_w-1:0] ctrl_addr   = 8'h00;
    localparam logic [addr_w-1:0] scale_addr  = 8'h10;
    localparam logic [addr_w-1:0] offset_addr = 8'h14;

    localparam logic [data_w-1:0] cmd_start = 32'h0000_0001;
    localparam logic [data_w-1:0] cmd_reset = 32'h0000_0004;
    localparam logic [data_w-1:0] cmd_load  = 32'h0000_0300;  // Load scale and offset
    localparam logic [data_w-1:0] cmd_apply = 32'h0000_0400;  // Apply loaded values

    localparam int status_done_bit = 1;    // Measurement finished flag
    localparam int host_ctrl_bit   = 6;    // Host address bit for the loop control words

    ////////////////////
    // Bus requests and commands
    typedef struct packed {
        logic              stb;
        logic              we;
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] dat;
    } bus_req_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] dat;
    } host_req_t;

    // Sequencer to bus master, one transaction each
    typedef struct packed {
        logic              we;
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] dat;
    } loop_cmd_t;

    typedef logic [n_info-1:0][data_w-1:0] info_words_t;

endpackage

/* agc_loop/agc_sequencer.sv */
module agc_sequencer (
    input  logic                               aclk,
    input  logic                               wb_rst_i,
    input  logic                               agc_restart_i,
    output agc_loop_pkg::loop_cmd_t            cmd_o,
    output logic                               cmd_valid_o,
    input  logic                               cmd_ready_i,
    input  logic                               rsp_valid_i,
    input  logic [agc_loop_pkg::data_w-1:0]    rsp_data_i,
    input  logic [agc_loop_pkg::scale_w-1:0]   new_scale_i,
    input  logic [agc_loop_pkg::offset_w-1:0]  new_offset_i,
    output logic                               calc_en_o,
    output agc_loop_pkg::info_words_t          info_o
);
    import agc_loop_pkg::*;

    typedef enum logic [3:0] {
        st_boot,
        st_wr_scale,
        st_wr_offset,
        st_load,
        st_apply,
        st_reset,
        st_start,
        st_poll,
        st_read_info,
        st_calc
    } seq_state_t;

    seq_state_t                         state_q;
    seq_state_t                         next_bus_state;
    logic [$clog2(boot_cycles+1)-1:0]   boot_cnt_q;
    logic [$clog2(n_info)-1:0]          info_idx_q;
    logic                               pending_q;     // Command accepted, response outstanding
    logic                               bus_step;
    logic                               last_info;
    info_words_t                        info_q;

    assign bus_step    = (state_q != st_boot) && (state_q != st_calc);
    assign cmd_valid_o = bus_step && !pending_q;
    assign calc_en_o   = (state_q == st_calc);
    assign last_info   = (info_idx_q == ($clog2(n_info))'(n_info - 1));
    assign info_o      = info_q;

    ////////////////////
    // Command for the current step
    always_comb begin
        cmd_o = '0;
        case (state_q)
            st_wr_scale: begin
                cmd_o.we  = 1'b1;
                cmd_o.adr = scale_addr;
                cmd_o.dat = data_w'(new_scale_i);
            end
            st_wr_offset: begin
                cmd_o.we  = 1'b1;
                cmd_o.adr = offset_addr;
                cmd_o.dat = {{(data_w-offset_w){new_offset_i[offset_w-1]}}, new_offset_i};
            end
            st_load:      cmd_o = '{we: 1'b1, adr: ctrl_addr, dat: cmd_load};
            st_apply:     cmd_o = '{we: 1'b1, adr: ctrl_addr, dat: cmd_apply};
            st_reset:     cmd_o = '{we: 1'b1, adr: ctrl_addr, dat: cmd_reset};
            st_start:     cmd_o = '{we: 1'b1, adr: ctrl_addr, dat: cmd_start};
            st_poll:      cmd_o.adr = ctrl_addr;                       // Status read
            st_read_info: cmd_o.adr = addr_w'({info_idx_q, 2'b00});    // Word address
            default: ;
        endcase
    end

    // Where a bus step goes once its response is back
    always_comb begin
        case (state_q)
            st_wr_scale:  next_bus_state = st_wr_offset;
            st_wr_offset: next_bus_state = st_load;
            st_load:      next_bus_state = st_apply;
            st_apply:     next_bus_state = st_reset;
            st_reset:     next_bus_state = st_start;
            st_start:     next_bus_state = st_poll;
            st_poll:      next_bus_state = rsp_data_i[status_done_bit] ? st_read_info : st_poll;
            st_read_info: next_bus_state = last_info ? st_calc : st_read_info;
            default:      next_bus_state = st_boot;
        endcase
    end

    ////////////////////
    // Loop control
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_restart_i) begin
            state_q    <= st_boot;
            boot_cnt_q <= ($clog2(boot_cycles+1))'(boot_cycles);
            info_idx_q <= '0;
            pending_q  <= 1'b0;
        end else begin
            if (cmd_valid_o && cmd_ready_i) pending_q <= 1'b1;
            if (rsp_valid_i) pending_q <= 1'b0;

            case (state_q)
                st_boot: begin
                    if (boot_cnt_q != '0) boot_cnt_q <= boot_cnt_q - 1'b1;
                    else state_q <= st_wr_scale;      // First pass uses the start values
                end
                st_calc: state_q <= st_wr_scale;
                default: begin
                    if (rsp_valid_i) begin
                        state_q <= next_bus_state;
                        if (state_q == st_poll) info_idx_q <= '0;
                        if (state_q == st_read_info) info_idx_q <= info_idx_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // Information store, refreshed each pass
    always_ff @(posedge aclk) begin
        if (rsp_valid_i && state_q == st_read_info) begin
            info_q[info_idx_q] <= rsp_data_i;
        end else if (rsp_valid_i && state_q == st_apply) begin
            info_q[info_scale_idx]  <= data_w'(new_scale_i);    // Applied values
            info_q[info_offset_idx] <= data_w'(new_offset_i);
        end
    end

endmodule

/* agc_loop/agc_bus_master.sv */
module agc_bus_master (
    input  logic                             aclk,
    input  logic                             wb_rst_i,
    input  logic                             agc_restart_i,
    input  agc_loop_pkg::loop_cmd_t          cmd_i,
    input  logic                             cmd_valid_i,
    output logic                             cmd_ready_o,
    output logic                             rsp_valid_o,
    output logic [agc_loop_pkg::data_w-1:0]  rsp_data_o,
    output agc_loop_pkg::bus_req_t           down_req_o,
    input  logic                             down_ack_i,
    input  logic [agc_loop_pkg::data_w-1:0]  down_dat_i
);
    import agc_loop_pkg::*;

    typedef enum logic {
        bm_idle,
        bm_wait
    } bm_state_t;

    bm_state_t   state_q;
    logic        stb_q;
    loop_cmd_t   cmd_q;        // Request fields held for the whole cycle
    logic        accept;

    assign cmd_ready_o = (state_q == bm_idle);
    assign accept      = cmd_valid_i && cmd_ready_o;

    assign down_req_o.stb = stb_q;
    assign down_req_o.we  = cmd_q.we;
    assign down_req_o.adr = cmd_q.adr;
    assign down_req_o.dat = cmd_q.dat;

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_restart_i) begin
            state_q     <= bm_idle;
            stb_q       <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;
            case (state_q)
                bm_idle: begin
                    if (accept) begin
                        stb_q   <= 1'b1;
                        state_q <= bm_wait;
                    end
                end
                bm_wait: begin
                    if (down_ack_i) begin     // Strobe drops the next cycle
                        stb_q       <= 1'b0;
                        rsp_valid_o <= 1'b1;
                        state_q     <= bm_idle;
                    end
                end
                default: state_q <= bm_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) cmd_q <= cmd_i;
        if (state_q == bm_wait && down_ack_i) rsp_data_o <= down_dat_i;  // Ack cycle data
    end

endmodule

/* agc_loop/agc_gain_calc.sv */
module agc_gain_calc (
    input  logic                               aclk,
    input  logic                               wb_rst_i,
    input  logic                               agc_restart_i,
    input  logic                               calc_en_i,
    input  agc_loop_pkg::info_words_t          info_i,
    output logic [agc_loop_pkg::scale_w-1:0]   scale_o,
    output logic [agc_loop_pkg::offset_w-1:0]  offset_o
);
    import agc_loop_pkg::*;

    logic [data_w-1:0]     rms_sq;
    logic [data_w-1:0]     cur_scale;
    logic [data_w:0]       above_cnt;
    logic [data_w:0]       below_cnt;
    logic [scale_w-1:0]    scale_next;
    logic [offset_w-1:0]   offset_next;

    assign rms_sq    = info_i[info_rms_idx] >> rms_shift;     // Reduced mean square
    assign cur_scale = info_i[info_scale_idx];
    assign above_cnt = {1'b0, info_i[info_above_idx]};
    assign below_cnt = {1'b0, info_i[info_below_idx]};

    ////////////////////
    // Fixed step rules
    always_comb begin
        scale_next = scale_o;
        if (rms_sq > data_w'(target_rms_sq + rms_sq_tol)) begin
            // Too loud so back off the gain
            if (cur_scale > data_w'(scale_floor))
                scale_next = cur_scale[scale_w-1:0] - scale_w'(scale_step);
            else
                scale_next = cur_scale[scale_w-1:0];
        end else if (rms_sq < data_w'(target_rms_sq - rms_sq_tol)) begin
            if (cur_scale < data_w'(scale_ceil))
                scale_next = cur_scale[scale_w-1:0] + scale_w'(scale_step);
            else
                scale_next = cur_scale[scale_w-1:0];
        end
    end

    always_comb begin
        offset_next = offset_o;
        if (above_cnt > below_cnt + (data_w+1)'(offset_tol))
            offset_next = info_i[info_offset_idx][offset_w-1:0] - offset_w'(offset_step);
        else if (below_cnt > above_cnt + (data_w+1)'(offset_tol))
            offset_next = info_i[info_offset_idx][offset_w-1:0] + offset_w'(offset_step);
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_restart_i) begin
            scale_o  <= start_scale;
            offset_o <= start_offset;
        end else if (calc_en_i) begin
            scale_o  <= scale_next;
            offset_o <= offset_next;
        end
    end

endmodule

/* verilog/agc_host_regs.sv */
module agc_host_regs (
    input  logic                             aclk,
    input  logic                             wb_rst_i,
    input  agc_loop_pkg::host_req_t          host_req_i,
    output logic                             host_ack_o,
    output logic [agc_loop_pkg::data_w-1:0]  host_dat_o,
    input  agc_loop_pkg::info_words_t        info_i
);
    import agc_loop_pkg::*;

    typedef enum logic [1:0] {
        hr_idle,
        hr_access,
        hr_ack
    } host_state_t;

    host_state_t         state_q;
    logic [3:0]          reg_idx;
    logic [data_w-1:0]   rd_word;
    logic [data_w-1:0]   resp_q;

    assign reg_idx    = host_req_i.adr[5:2];
    assign host_ack_o = (state_q == hr_ack);
    assign host_dat_o = resp_q;

    ////////////////////
    // Read decode
    always_comb begin
        rd_word = '0;
        if (host_req_i.adr[host_ctrl_bit]) begin
            if (reg_idx == 4'd0) rd_word = data_w'(scale_w'(scale_step));
            else if (reg_idx == 4'd1) rd_word = data_w'($signed(offset_w'(offset_step)));
        end else if (reg_idx < 4'(n_info)) begin
            rd_word = info_i[reg_idx[2:0]];
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state_q <= hr_idle;
        end else begin
            case (state_q)
                hr_idle:   if (host_req_i.cyc && host_req_i.stb) state_q <= hr_access;
                hr_access: state_q <= hr_ack;
                hr_ack:    state_q <= hr_idle;
                default:   state_q <= hr_idle;
            endcase
        end
    end

    // Writes only get their ack
    always_ff @(posedge aclk) begin
        if (state_q == hr_access && !host_req_i.we) resp_q <= rd_word;
    end

endmodule

/* verilog/agc_loop_top.sv */
module agc_loop_top (
    input  logic                             aclk,
    input  logic                             wb_rst_i,
    input  logic                             agc_restart_i,

    // Host register port
    input  agc_loop_pkg::host_req_t          host_req_i,
    output logic                             host_ack_o,
    output logic [agc_loop_pkg::data_w-1:0]  host_dat_o,

    // Downstream AGC module
    output agc_loop_pkg::bus_req_t           down_req_o,
    input  logic                             down_ack_i,
    input  logic [agc_loop_pkg::data_w-1:0]  down_dat_i
);
    import agc_loop_pkg::*;

    loop_cmd_t             cmd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  rsp_valid;
    logic [data_w-1:0]     rsp_data;
    logic [scale_w-1:0]    new_scale;
    logic [offset_w-1:0]   new_offset;
    logic                  calc_en;
    info_words_t           info;

    agc_sequencer u_sequencer (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_restart_i (agc_restart_i),
        .cmd_o         (cmd),
        .cmd_valid_o   (cmd_valid),
        .cmd_ready_i   (cmd_ready),
        .rsp_valid_i   (rsp_valid),
        .rsp_data_i    (rsp_data),
        .new_scale_i   (new_scale),
        .new_offset_i  (new_offset),
        .calc_en_o     (calc_en),
        .info_o        (info)
    );

    agc_bus_master u_bus_master (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_restart_i (agc_restart_i),
        .cmd_i         (cmd),
        .cmd_valid_i   (cmd_valid),
        .cmd_ready_o   (cmd_ready),
        .rsp_valid_o   (rsp_valid),
        .rsp_data_o    (rsp_data),
        .down_req_o    (down_req_o),
        .down_ack_i    (down_ack_i),
        .down_dat_i    (down_dat_i)
    );

    agc_gain_calc u_gain_calc (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_restart_i (agc_restart_i),
        .calc_en_i     (calc_en),
        .info_i        (info),
        .scale_o       (new_scale),
        .offset_o      (new_offset)
    );

    // Host side stays up across a loop restart
    agc_host_regs u_host_regs (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .host_req_i    (host_req_i),
        .host_ack_o    (host_ack_o),
        .host_dat_o    (host_dat_o),
        .info_i        (info)
    );

endmodule

/* dv/agc_loop_sva.sv */
module agc_loop_sva (
    input logic                   aclk,
    input logic                   wb_rst_i,
    input logic                   agc_restart_i,
    input agc_loop_pkg::bus_req_t down_req_o,
    input logic                   down_ack_i,
    input logic                   host_ack_o
);

    ////////////////////
    // Downstream bus
    property stb_held_until_ack;
        @(posedge aclk) (!wb_rst_i && !agc_restart_i && down_req_o.stb && !down_ack_i)
            |=> (down_req_o.stb && $stable(down_req_o));
    endproperty

    property stb_low_after_reset;
        @(posedge aclk) wb_rst_i |=> !down_req_o.stb;
    endproperty

    // Host port ack is a single pulse
    property host_ack_single;
        @(posedge aclk) disable iff (wb_rst_i) host_ack_o |=> !host_ack_o;
    endproperty

    stb_held_a: assert property (stb_held_until_ack)
        else $error("Downstream request changed before ack");
    stb_reset_a: assert property (stb_low_after_reset)
        else $error("Downstream strobe high after reset");
    host_ack_a: assert property (host_ack_single)
        else $error("Host ack longer than one cycle");

endmodule

bind agc_loop_top agc_loop_sva sva_i (
    .aclk          (aclk),
    .wb_rst_i      (wb_rst_i),
    .agc_restart_i (agc_restart_i),
    .down_req_o    (down_req_o),
    .down_ack_i    (down_ack_i),
    .host_ack_o    (host_ack_o)
);

/* dv/agc_loop_tb.sv */
module agc_loop_tb;
    import agc_loop_pkg::*;

    localparam int txn_cycles     = 8;    // Accept, strobe, worst ack delay, response
    localparam int boot_len       = boot_cycles + 4;
    localparam int pass_short     = (12 + 2) * txn_cycles + 4;
    localparam int pass_long      = (12 + 24) * txn_cycles + 4;
    localparam int timeout_cycles = 16 + 2 * boot_len + 9 * pass_short + 3 * pass_long + 100;

    logic              aclk;
    logic              wb_rst_i;
    logic              agc_restart_i;
    host_req_t         host_req;
    logic              host_ack;
    logic [data_w-1:0] host_dat;
    bus_req_t          down_req;
    logic              down_ack;
    logic [data_w-1:0] down_dat;

    logic [data_w-1:0] model_words [n_info];   // Words the AGC model reports
    logic [addr_w-1:0] wr_adr_q [$];
    logic [data_w-1:0] wr_dat_q [$];
    logic [addr_w-1:0] rd_adr_q [$];
    int                done_n;                 // Poll that reports done
    int                poll_cnt;
    logic              meas_done;
    logic              in_txn;
    int                ack_wait;
    logic [31:0]       rnd_state;
    int                err_cnt;
    int                chk_cnt;
    int                cyc_cnt;

    agc_loop_top dut_i (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_restart_i (agc_restart_i),
        .host_req_i    (host_req),
        .host_ack_o    (host_ack),
        .host_dat_o    (host_dat),
        .down_req_o    (down_req),
        .down_ack_i    (down_ack),
        .down_dat_i    (down_dat)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////
    // Downstream AGC model
    task automatic serve_request();
        int idx;
        idx = int'(down_req.adr[addr_w-1:2]);
        down_dat = '0;
        if (down_req.we) begin
            wr_adr_q.push_back(down_req.adr);
            wr_dat_q.push_back(down_req.dat);
            if (down_req.adr == ctrl_addr && down_req.dat == cmd_start) begin
                poll_cnt  = 0;                     // New measurement
                meas_done = 1'b0;
            end
        end else begin
            rd_adr_q.push_back(down_req.adr);
            if (down_req.adr == ctrl_addr && !meas_done) begin
                poll_cnt = poll_cnt + 1;
                if (poll_cnt >= done_n) begin
                    meas_done = 1'b1;
                    down_dat  = data_w'(1) << status_done_bit;
                end
            end else if (idx < n_info) begin
                down_dat = model_words[idx];       // Word 0 shares the status address
            end
        end
    endtask

    always @(negedge aclk) begin
        if (down_ack) begin
            down_ack = 1'b0;
        end else if (down_req.stb) begin
            if (!in_txn) begin
                in_txn    = 1'b1;
                rnd_state = xorshift32(rnd_state);
                ack_wait  = int'(rnd_state[1:0]);  // 0 to 3 cycles
            end
            if (ack_wait == 0) begin
                serve_request();
                in_txn   = 1'b0;
                down_ack = 1'b1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end else begin
            in_txn = 1'b0;                         // Strobe dropped by a restart
        end
    end

    // Watchdog
    initial begin
        cyc_cnt = 0;
        while (cyc_cnt < timeout_cycles) begin
            @(posedge aclk);
            cyc_cnt = cyc_cnt + 1;
        end
        $display("Timeout after %0d cycles, the control loop stopped making progress", cyc_cnt);
        $display("Errors found");
        $finish;
    end

    ////////////////////
    // Helpers
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt = chk_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) $display("Test %s: ok", name);
        else $display("Test %s: %0d failed checks", name, err_cnt - errs_before);
    endtask

    task automatic wait_writes(input int n);
        while (wr_adr_q.size() < n) @(posedge aclk);
    endtask

    task automatic host_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                               output logic [31:0] rdat);
        int lat;
        @(negedge aclk);
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        lat = 0;
        do begin
            @(negedge aclk);
            lat = lat + 1;
        end while (!host_ack && lat < 10);
        check_value("host_ack_o latency", 32'(lat), 32'd2);
        rdat     = host_dat;
        host_req = '0;
        @(negedge aclk);
        check_value("host_ack_o after ack cycle", 32'(host_ack), 32'd0);
    endtask

    // Six writes that open a pass from the start values
    task automatic check_start_writes(input int base);
        logic [31:0] exp_adr [6];
        logic [31:0] exp_dat [6];
        exp_adr = '{32'h10, 32'h14, 32'h00, 32'h00, 32'h00, 32'h00};
        exp_dat = '{32'd1800, 32'd0, 32'h300, 32'h400, 32'h04, 32'h01};
        wait_writes(base + 6);
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("down_req_o.adr of write %0d", i),
                        32'(wr_adr_q[base + i]), exp_adr[i]);
            check_value($sformatf("down_req_o.dat of write %0d", i),
                        wr_dat_q[base + i], exp_dat[i]);
        end
    endtask

    // Loads the model words before a pass reads them, returns the next writes
    task automatic run_round(input logic [31:0] w0, w1, w2, w3, w4, w5,
                             output logic [31:0] scale, output logic [31:0] offset);
        int s;
        s = ((wr_adr_q.size() + 5) / 6) * 6;
        wait_writes(s + 1);
        model_words[0] = w0;
        model_words[1] = w1;
        model_words[2] = w2;
        model_words[3] = w3;
        model_words[4] = w4;
        model_words[5] = w5;
        wait_writes(s + 8);
        check_value("scale write address", 32'(wr_adr_q[s + 6]), 32'h10);
        check_value("offset write address", 32'(wr_adr_q[s + 7]), 32'h14);
        scale  = wr_dat_q[s + 6];
        offset = wr_dat_q[s + 7];
    endtask

    ////////////////////
    // Tests
    task automatic test_boot();
        int e0;
        e0 = err_cnt;
        check_start_writes(0);
        while (rd_adr_q.size() < 1) @(posedge aclk);
        check_value("first read address", 32'(rd_adr_q[0]), 32'h00);
        report_test("boot sequence", e0);
    endtask

    task automatic test_host();
        int e0;
        logic [31:0] rd;
        e0 = err_cnt;
        host_access(1'b0, 8'h40, 32'd0, rd);
        check_value("host_dat_o at 0x40", rd, 32'd30);
        host_access(1'b0, 8'h44, 32'd0, rd);
        check_value("host_dat_o at 0x44", rd, 32'd25);
        host_access(1'b0, 8'h48, 32'd0, rd);
        check_value("host_dat_o at 0x48", rd, 32'd0);
        host_access(1'b1, 8'h40, 32'h1234_5678, rd);   // Ignored write
        host_access(1'b0, 8'h40, 32'd0, rd);
        check_value("host_dat_o at 0x40 after write", rd, 32'd30);
        report_test("host reads", e0);
    endtask

    task automatic test_scale_down();
        int e0;
        logic [31:0] sc;
        logic [31:0] of;
        e0 = err_cnt;
        run_round(32'd0, 32'd20 << 13, 32'd50, 32'd10, 32'd1800, 32'd100, sc, of);
        check_value("scale write data", sc, 32'd1770);
        check_value("offset write data", of, 32'd75);
        report_test("scale down", e0);
    endtask

    task automatic test_limits();
        int e0;
        logic [31:0] sc;
        logic [31:0] of;
        e0 = err_cnt;
        run_round(32'd0, 32'd0, 32'd3, 32'd40, 32'd1770, 32'd75, sc, of);
        check_value("scale write data", sc, 32'd1800);
        check_value("offset write data", of, 32'd100);
        run_round(32'd0, 32'd100 << 13, 32'd10, 32'd10, 32'd200, 32'd100, sc, of);
        check_value("scale write data at floor", sc, 32'd200);
        check_value("offset write data in band", of, 32'd100);
        report_test("limits and scale up", e0);
    endtask

    task automatic test_readback();
        int e0;
        int n;
        logic [31:0] sc;
        logic [31:0] of;
        logic [31:0] rd;
        logic [31:0] exp [6];
        e0  = err_cnt;
        // Words 4 and 5 hold the applied scale and offset, not the model's 200 and 100
        exp = '{32'h0bad_f00d, 32'h0002_0000, 32'd7, 32'd40, 32'd200, 32'd125};
        done_n = 24;                               // Long poll keeps the info reads away
        run_round(exp[0], exp[1], exp[2], exp[3], 32'd200, 32'd100, sc, of);
        check_value("scale write data", sc, 32'd200);
        check_value("offset write data", of, 32'd125);
        n = wr_adr_q.size();
        wait_writes(n + 2);
        check_value("apply command", wr_dat_q[n + 1], 32'h400);
        repeat (3) @(posedge aclk);
        for (int i = 0; i < 6; i++) begin
            host_access(1'b0, 8'(i * 4), 32'd0, rd);
            check_value($sformatf("host_dat_o of info word %0d", i), rd, exp[i]);
        end
        done_n = 2;
        report_test("readback", e0);
    endtask

    task automatic test_restart();
        int e0;
        int n;
        e0 = err_cnt;
        n  = wr_adr_q.size();
        wait_writes(n + 2);
        @(negedge aclk);
        agc_restart_i = 1'b1;
        @(negedge aclk);
        agc_restart_i = 1'b0;
        @(posedge aclk);
        wr_adr_q.delete();
        wr_dat_q.delete();
        rd_adr_q.delete();
        check_start_writes(0);
        report_test("restart", e0);
    endtask

    initial begin
        wb_rst_i      = 1'b1;
        agc_restart_i = 1'b0;
        host_req      = '0;
        down_ack      = 1'b0;
        down_dat      = '0;
        rnd_state     = 32'h3f99;
        done_n        = 2;
        poll_cnt      = 0;
        meas_done     = 1'b0;
        in_txn        = 1'b0;
        ack_wait      = 0;
        err_cnt       = 0;
        chk_cnt       = 0;
        model_words   = '{32'd0, 32'd16 << 13, 32'd0, 32'd0, 32'd1800, 32'd0};  // In band
        repeat (16) @(negedge aclk);
        wb_rst_i = 1'b0;

        test_boot();
        test_host();
        test_scale_down();
        test_limits();
        test_readback();
        test_restart();

        $display("Checks run: %0d, failed: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) $display("No errors");
        else $display("Errors found");
        $finish;
    end

endmodule

/* tb.f */
common/agc_loop_pkg.sv
agc_loop/agc_sequencer.sv
agc_loop/agc_bus_master.sv
agc_loop/agc_gain_calc.sv
verilog/agc_host_regs.sv
verilog/agc_loop_top.sv
dv/agc_loop_sva.sv
dv/agc_loop_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module agc_loop_tb -o agc_loop_sim

# An assertion stops the run early, so the log decides the result
./obj_dir/agc_loop_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1
